//--- source/saturn_bus_pkg.sv
package saturn_bus_pkg;

    // One nibble on the bus.
    typedef logic [3:0] nibble_t;

    // Entry kind, top bit of a program entry.
    typedef enum logic {
        BUS_DATA = 1'b0,  // Data nibble.
        BUS_CMD  = 1'b1   // Command nibble.
    } bus_kind_e;

    // Program entry, 5 bits packed.
    typedef struct packed {
        bus_kind_e kind;    // Bit 4.
        nibble_t   nibble;  // Bits 3:0.
    } prog_entry_t;

    // Four phases of one bus cycle, one clock each.
    typedef enum logic [1:0] {
        PH_SEND   = 2'd0,  // Drive entry or start read.
        PH_READ   = 2'd1,  // Sample returned nibble.
        PH_DECODE = 2'd2,  // Busy update.
        PH_EXEC   = 2'd3   // Idle.
    } bus_phase_e;

    // Register map, PADDR[3:0].
    typedef enum logic [3:0] {
        REG_CTRL   = 4'h0,  // Read enable, halt clear.
        REG_STATUS = 4'h4,  // Busy, halt, counts.
        REG_PROG   = 4'h8,  // Program write port.
        REG_RDATA  = 4'hC   // FIFO pop.
    } apb_reg_e;

    // Ring index width, 32 slots.
    localparam int PROG_ADDR_W = 5;

endpackage

//--- source/saturn_apb_regs.sv
`timescale 1ns/1ps

module saturn_apb_regs #(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [7:0]                          i_paddr,
    input  logic [31:0]                         i_pwdata,
    output logic [31:0]                         o_prdata,
    output logic                                o_pready,
    output logic                                o_pslverr,
    input  logic                                i_prog_full,
    input  logic [saturn_bus_pkg::PROG_ADDR_W-1:0] i_prog_count,
    input  saturn_bus_pkg::nibble_t             i_fifo_rdata,
    input  logic [FIFO_DEPTH_LOG2:0]            i_fifo_count,
    input  logic                                i_fifo_empty,
    input  logic                                i_busy,
    output logic                                o_prog_wr,
    output saturn_bus_pkg::prog_entry_t         o_prog_wdata,
    output logic                                o_fifo_pop,
    output logic                                o_read_enable,
    output logic                                o_halt
);

    import saturn_bus_pkg::*;

    logic     access;     // APB access phase.
    logic     wr_access;  // Write in access phase.
    logic     rd_access;  // Read in access phase.
    apb_reg_e reg_addr;   // Decoded register.
    logic     mapped;     // Address hits the map.
    logic     prog_err;   // Write to a full ring.
    logic     rdata_err;  // Pop of an empty FIFO.

    assign access    = i_psel & i_penable;          // No wait states.
    assign wr_access = access & i_pwrite;
    assign rd_access = access & ~i_pwrite;
    assign reg_addr  = apb_reg_e'(i_paddr[3:0]);    // Low nibble selects.

    // Upper address bits must be zero and the offset one of four.
    assign mapped = (i_paddr[7:4] == 4'h0) &&
                    (reg_addr inside {REG_CTRL, REG_STATUS, REG_PROG, REG_RDATA});

    assign prog_err  = wr_access & mapped & (reg_addr == REG_PROG) & i_prog_full;
    assign rdata_err = rd_access & mapped & (reg_addr == REG_RDATA) & i_fifo_empty;

    assign o_pready  = 1'b1;                        // Always ready.
    assign o_pslverr = (access & ~mapped) | prog_err | rdata_err;

    // Program write port, only when the ring has room.
    assign o_prog_wr    = wr_access & mapped & (reg_addr == REG_PROG) & ~i_prog_full;
    assign o_prog_wdata = prog_entry_t'(i_pwdata[4:0]);  // Kind at bit 4.

    // RDATA read pops one nibble.
    assign o_fifo_pop = rd_access & mapped & (reg_addr == REG_RDATA) & ~i_fifo_empty;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_read_enable <= 1'b0;             // Reads off.
            o_halt        <= 1'b0;             // Running.
        end else begin
            if (wr_access && mapped && reg_addr == REG_CTRL) begin
                o_read_enable <= i_pwdata[0];  // Bit 0 read enable.
                if (i_pwdata[1]) begin
                    o_halt <= 1'b0;            // Write 1 clears halt.
                end
            end
            if (o_pslverr) begin
                o_halt <= 1'b1;                // Sticky on any error.
            end
        end
    end

    // Read mux.
    always_comb begin
        o_prdata = 32'h0;
        if (rd_access && mapped) begin
            case (reg_addr)
                REG_CTRL: begin
                    o_prdata[0] = o_read_enable;           // Bit 1 reads 0.
                end
                REG_STATUS: begin
                    o_prdata[0]   = i_busy;
                    o_prdata[1]   = o_halt;
                    o_prdata[6:2] = i_prog_count;          // Pending entries.
                    o_prdata[8 +: FIFO_DEPTH_LOG2 + 1] = i_fifo_count;
                end
                REG_RDATA: begin
                    o_prdata[3:0] = i_fifo_rdata;          // FIFO head.
                end
                default: begin
                    o_prdata = 32'h0;                      // PROG is write only.
                end
            endcase
        end
    end

endmodule

//--- source/saturn_bus_program.sv
`timescale 1ns/1ps

module saturn_bus_program (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_wr,
    input  saturn_bus_pkg::prog_entry_t            i_wdata,
    input  logic                                   i_pop,
    output saturn_bus_pkg::prog_entry_t            o_entry,
    output logic                                   o_pending,
    output logic                                   o_full,
    output logic [saturn_bus_pkg::PROG_ADDR_W-1:0] o_count
);

    import saturn_bus_pkg::*;

    localparam int SLOTS = 1 << PROG_ADDR_W;   // 32 slots.

    prog_entry_t            ring [SLOTS];  // Entry storage.
    logic [PROG_ADDR_W-1:0] wr_ptr;        // Last written slot.
    logic [PROG_ADDR_W-1:0] snd_ptr;       // Last sent slot.
    logic [PROG_ADDR_W-1:0] wr_next;       // Slot for next write.
    logic [PROG_ADDR_W-1:0] snd_next;      // Slot for next send.

    assign wr_next  = wr_ptr + 1'b1;       // Wraps at 32.
    assign snd_next = snd_ptr + 1'b1;

    // Both pointers name the last used slot, hence the pre-increment.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr  <= '1;                 // Slot 31.
            snd_ptr <= '1;                 // Slot 31.
        end else begin
            if (i_wr) begin
                wr_ptr <= wr_next;
            end
            if (i_pop) begin
                snd_ptr <= snd_next;
            end
        end
    end

    // New entry lands in the slot after the last written one.
    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            ring[wr_next] <= i_wdata;
        end
    end

    assign o_entry   = ring[snd_next];        // Next entry to send.
    assign o_count   = wr_ptr - snd_ptr;      // Modulo 32.
    assign o_pending = (wr_ptr != snd_ptr);
    assign o_full    = (o_count == PROG_ADDR_W'(SLOTS - 1));  // 31 pending.

endmodule

//--- source/saturn_bus_sequencer.sv
`timescale 1ns/1ps

module saturn_bus_sequencer (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_halt,
    input  logic                        i_read_enable,
    input  saturn_bus_pkg::prog_entry_t i_entry,
    input  logic                        i_pending,
    input  logic                        i_fifo_full,
    input  saturn_bus_pkg::nibble_t     i_bus_nibble_in,
    output logic                        o_pop,
    output logic                        o_push,
    output saturn_bus_pkg::nibble_t     o_push_nibble,
    output logic                        o_busy,
    output logic                        o_bus_clk_en,
    output logic                        o_bus_is_data,
    output saturn_bus_pkg::nibble_t     o_bus_nibble_out
);

    import saturn_bus_pkg::*;

    bus_phase_e phase;      // Current phase.
    logic       read_cyc;   // This cycle is a read.
    logic       do_send;    // Send an entry now.
    logic       do_read;    // Start a read now.

    assign do_send = ~i_halt & (phase == PH_SEND) & i_pending;
    assign do_read = ~i_halt & (phase == PH_SEND) & ~i_pending &
                     i_read_enable & ~i_fifo_full;

    assign o_pop         = do_send;                                  // Take head entry.
    assign o_push        = ~i_halt & (phase == PH_READ) & read_cyc;  // Capture now.
    assign o_push_nibble = i_bus_nibble_in;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase        <= PH_SEND;       // First clock sends.
            read_cyc     <= 1'b0;
            o_bus_clk_en <= 1'b0;
            o_busy       <= 1'b0;
        end else if (i_halt) begin
            o_bus_clk_en <= 1'b0;          // Frozen, strobe low.
            if (i_pending) begin
                o_busy <= 1'b1;            // Writes still count.
            end
        end else begin
            phase <= bus_phase_e'(phase + 2'd1);  // Wraps after EXEC.
            if (i_pending) begin
                o_busy <= 1'b1;
            end
            case (phase)
                PH_SEND: begin
                    if (do_send) begin
                        o_bus_clk_en <= 1'b1;
                    end else if (do_read) begin
                        o_bus_clk_en <= 1'b1;      // Device drives in READ.
                        read_cyc     <= 1'b1;
                    end
                end
                PH_READ: begin
                    o_bus_clk_en <= 1'b0;          // Strobe ends.
                    read_cyc     <= 1'b0;          // Captured above.
                end
                PH_DECODE: begin
                    if (!i_pending) begin
                        o_busy <= 1'b0;            // Ring drained.
                    end
                end
                default: begin
                end                                // EXEC idles.
            endcase
        end
    end

    // Bus payload, held between cycles.
    always_ff @(posedge i_clk) begin
        if (do_send) begin
            o_bus_is_data    <= ~i_entry.kind;    // Data when not a command.
            o_bus_nibble_out <= i_entry.nibble;
        end else if (do_read) begin
            o_bus_is_data    <= 1'b1;             // Reads look like data.
        end
    end

endmodule

//--- source/saturn_read_fifo.sv
`timescale 1ns/1ps

module saturn_read_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_push,
    input  saturn_bus_pkg::nibble_t  i_nibble,
    input  logic                     i_pop,
    output saturn_bus_pkg::nibble_t  o_nibble,
    output logic [FIFO_DEPTH_LOG2:0] o_count,
    output logic                     o_empty,
    output logic                     o_full
);

    import saturn_bus_pkg::*;

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    nibble_t                    mem [DEPTH];  // Storage.
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;       // Next free slot.
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;       // Head slot.
    logic                       do_push;
    logic                       do_pop;

    assign do_push = i_push & ~o_full;    // Drop on overflow.
    assign do_pop  = i_pop & ~o_empty;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                o_count <= o_count + 1'b1;
            end else if (do_pop && !do_push) begin
                o_count <= o_count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_nibble;
        end
    end

    assign o_nibble = mem[rd_ptr];        // Fall-through head.
    assign o_empty  = (o_count == '0);
    assign o_full   = (o_count == (FIFO_DEPTH_LOG2 + 1)'(DEPTH));

endmodule

//--- source/saturn_bus_top.sv
`timescale 1ns/1ps

module saturn_bus_top #(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  logic [7:0]              i_paddr,
    input  logic [31:0]             i_pwdata,
    output logic [31:0]             o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,
    output logic                    o_bus_clk_en,
    output logic                    o_bus_is_data,
    output saturn_bus_pkg::nibble_t o_bus_nibble_out,
    input  saturn_bus_pkg::nibble_t i_bus_nibble_in
);

    import saturn_bus_pkg::*;

    logic                     prog_wr;      // Host to ring.
    prog_entry_t              prog_wdata;
    logic                     prog_full;
    logic [PROG_ADDR_W-1:0]   prog_count;
    prog_entry_t              prog_entry;   // Ring to sequencer.
    logic                     prog_pending;
    logic                     prog_pop;
    logic                     fifo_push;    // Sequencer to FIFO.
    nibble_t                  fifo_wdata;
    logic                     fifo_pop;     // Host pops.
    nibble_t                  fifo_rdata;
    logic [FIFO_DEPTH_LOG2:0] fifo_count;
    logic                     fifo_empty;
    logic                     fifo_full;
    logic                     busy;
    logic                     read_enable;
    logic                     halt;

    saturn_apb_regs #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_regs (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_paddr       (i_paddr),
        .i_pwdata      (i_pwdata),
        .o_prdata      (o_prdata),
        .o_pready      (o_pready),
        .o_pslverr     (o_pslverr),
        .i_prog_full   (prog_full),
        .i_prog_count  (prog_count),
        .i_fifo_rdata  (fifo_rdata),
        .i_fifo_count  (fifo_count),
        .i_fifo_empty  (fifo_empty),
        .i_busy        (busy),
        .o_prog_wr     (prog_wr),
        .o_prog_wdata  (prog_wdata),
        .o_fifo_pop    (fifo_pop),
        .o_read_enable (read_enable),
        .o_halt        (halt)
    );

    saturn_bus_program u_program (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wr      (prog_wr),
        .i_wdata   (prog_wdata),
        .i_pop     (prog_pop),
        .o_entry   (prog_entry),
        .o_pending (prog_pending),
        .o_full    (prog_full),
        .o_count   (prog_count)
    );

    saturn_bus_sequencer u_sequencer (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_halt           (halt),
        .i_read_enable    (read_enable),
        .i_entry          (prog_entry),
        .i_pending        (prog_pending),
        .i_fifo_full      (fifo_full),
        .i_bus_nibble_in  (i_bus_nibble_in),
        .o_pop            (prog_pop),
        .o_push           (fifo_push),
        .o_push_nibble    (fifo_wdata),
        .o_busy           (busy),
        .o_bus_clk_en     (o_bus_clk_en),
        .o_bus_is_data    (o_bus_is_data),
        .o_bus_nibble_out (o_bus_nibble_out)
    );

    saturn_read_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_fifo (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_push   (fifo_push),
        .i_nibble (fifo_wdata),
        .i_pop    (fifo_pop),
        .o_nibble (fifo_rdata),
        .o_count  (fifo_count),
        .o_empty  (fifo_empty),
        .o_full   (fifo_full)
    );

endmodule

//--- sim/saturn_bus_model.sv
`timescale 1ns/1ps

module saturn_bus_model (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_bus_clk_en,
    input  logic                    i_bus_is_data,
    input  saturn_bus_pkg::nibble_t i_bus_nibble,
    input  logic                    i_read_cycle,
    output saturn_bus_pkg::nibble_t o_bus_nibble
);

    import saturn_bus_pkg::*;

    nibble_t counter;  // Device address counter.

    // Strobe high for one clock per bus cycle.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            counter <= '0;
        end else if (i_bus_clk_en) begin
            if (i_read_cycle) begin
                counter <= counter + 4'd1;           // Step after the read.
            end else if (!i_bus_is_data) begin
                counter <= i_bus_nibble;             // Command loads.
            end else begin
                counter <= counter + i_bus_nibble;   // Data adds, modulo 16.
            end
        end
    end

    // Driven all the time, sampled by the DUT in PH_READ.
    assign o_bus_nibble = counter;

endmodule

//--- sim/tb_saturn_bus.sv
`timescale 1ns/1ps

module tb_saturn_bus;

    import saturn_bus_pkg::*;

    localparam int  FIFO_DEPTH_LOG2 = 3;
    localparam int  FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
    localparam time PERIOD          = 40;
    localparam time DRIVE_DLY       = 2;   // After the rising edge.
    localparam int  NUM_TESTS       = 6;
    localparam time WATCHDOG_NS     = NUM_TESTS * 200 * 4 * PERIOD;  // 200 bus cycles each.

    logic        i_clk;
    logic        i_reset;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    logic [7:0]  i_paddr;
    logic [31:0] i_pwdata;
    logic [31:0] o_prdata;
    logic        o_pready;
    logic        o_pslverr;
    logic        o_bus_clk_en;
    logic        o_bus_is_data;
    nibble_t     o_bus_nibble_out;
    nibble_t     i_bus_nibble_in;

    prog_entry_t mon_q[$];     // Seen on the bus.
    prog_entry_t exp_q[$];     // Written to PROG.
    int          n_checks;
    int          n_errors;
    int          n_tests;
    int          n_failed;
    int          test_err_base;
    string       test_name;

    saturn_bus_top #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) DUT (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_psel           (i_psel),
        .i_penable        (i_penable),
        .i_pwrite         (i_pwrite),
        .i_paddr          (i_paddr),
        .i_pwdata         (i_pwdata),
        .o_prdata         (o_prdata),
        .o_pready         (o_pready),
        .o_pslverr        (o_pslverr),
        .o_bus_clk_en     (o_bus_clk_en),
        .o_bus_is_data    (o_bus_is_data),
        .o_bus_nibble_out (o_bus_nibble_out),
        .i_bus_nibble_in  (i_bus_nibble_in)
    );

    // Read cycles look like data on the pins, so the model taps the sequencer.
    saturn_bus_model u_model (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_bus_clk_en  (o_bus_clk_en),
        .i_bus_is_data (o_bus_is_data),
        .i_bus_nibble  (o_bus_nibble_out),
        .i_read_cycle  (DUT.u_sequencer.read_cyc),
        .o_bus_nibble  (i_bus_nibble_in)
    );

    initial begin
        i_clk = 1'b0;
        forever #(PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR at %0t ns: watchdog expired before the tests finished", $time);
        $display("Regression failed");
        $finish;
    end

    // Strobe is high one full clock, so mid-cycle catches it once.
    always @(negedge i_clk) begin
        prog_entry_t seen;
        if (!i_reset && o_bus_clk_en) begin
            seen.kind   = o_bus_is_data ? BUS_DATA : BUS_CMD;  // Data pin high means data.
            seen.nibble = o_bus_nibble_out;
            mon_q.push_back(seen);
        end
    end

    // Entry as laid out in a PROG write, kind at bit 4.
    function automatic prog_entry_t entry_from_bits(input logic [4:0] w);
        prog_entry_t e;
        e.kind   = w[4] ? BUS_CMD : BUS_DATA;
        e.nibble = w[3:0];
        return e;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        n_errors++;
    endtask

    task automatic check_nibble(input string what, input nibble_t got, input nibble_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = 0x%h, expected 0x%h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_kind(input string what, input bus_kind_e got, input bus_kind_e exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = %s, expected %s", $time, what,
                     got.name(), exp.name());
            n_errors++;
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = 0x%h, expected 0x%h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge i_clk);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge i_clk);
        #DRIVE_DLY;
        i_psel    = 1'b1;                  // Setup phase.
        i_penable = 1'b0;
        i_pwrite  = 1'b1;
        i_paddr   = addr;
        i_pwdata  = data;
        @(posedge i_clk);
        #DRIVE_DLY;
        i_penable = 1'b1;                  // Access phase.
        @(negedge i_clk);
        err = o_pslverr;
        check_word("o_pready", 32'(o_pready), 32'd1);
        @(posedge i_clk);
        #DRIVE_DLY;
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge i_clk);
        #DRIVE_DLY;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = addr;
        @(posedge i_clk);
        #DRIVE_DLY;
        i_penable = 1'b1;
        @(negedge i_clk);
        data = o_prdata;                   // Stable mid-cycle.
        err  = o_pslverr;
        check_word("o_pready", 32'(o_pready), 32'd1);
        @(posedge i_clk);
        #DRIVE_DLY;
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(8'(REG_STATUS), st, err);
        while (st[0] && polls < 200) begin
            apb_read(8'(REG_STATUS), st, err);
            polls++;
        end
        if (st[0]) begin
            report_error("STATUS busy never cleared");
        end
    endtask

    task automatic wait_fifo(input int level);
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(8'(REG_STATUS), st, err);
        while (int'(st[11:8]) < level && polls < 200) begin
            apb_read(8'(REG_STATUS), st, err);
            polls++;
        end
        if (int'(st[11:8]) < level) begin
            report_error($sformatf("read FIFO never reached %0d entries", level));
        end
    endtask

    task automatic wait_sent(input int n);
        int cycles;
        cycles = 0;
        while (mon_q.size() < n && cycles < (n + 4) * 8) begin
            @(posedge i_clk);
            cycles++;
        end
        if (mon_q.size() < n) begin
            report_error($sformatf("only %0d of %0d entries reached the bus", mon_q.size(), n));
        end
    endtask

    task automatic check_sent(input int n);
        int i;
        check_word("bus strobe count", 32'(mon_q.size()), 32'(n));
        for (i = 0; i < n && i < mon_q.size(); i++) begin
            check_kind($sformatf("bus[%0d].kind", i), mon_q[i].kind, exp_q[i].kind);
            check_nibble($sformatf("bus[%0d].nibble", i), mon_q[i].nibble, exp_q[i].nibble);
        end
    endtask

    task automatic pop_rdata(output nibble_t val);
        logic [31:0] data;
        logic        err;
        wait_fifo(1);
        apb_read(8'(REG_RDATA), data, err);
        check_word("o_pslverr on RDATA", 32'(err), 32'd0);
        val = data[3:0];
    endtask

    // Turns reads off and pops what is left, still in sequence.
    task automatic stop_reads_and_drain(inout nibble_t expect_n);
        logic [31:0] st;
        logic        err;
        nibble_t     got;
        int          n;
        apb_write(8'(REG_CTRL), 32'h0, err);
        wait_clocks(8);                    // Let an open read cycle land.
        apb_read(8'(REG_STATUS), st, err);
        n = int'(st[11:8]);
        repeat (n) begin
            pop_rdata(got);
            check_nibble("o_prdata RDATA", got, expect_n);
            expect_n = expect_n + 4'd1;
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = n_errors;
        mon_q.delete();
        exp_q.delete();
        n_tests++;
    endtask

    task automatic end_test();
        if (n_errors == test_err_base) begin
            $display("PASS %s", test_name);
        end else begin
            $display("FAIL %s (%0d errors)", test_name, n_errors - test_err_base);
            n_failed++;
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] st;
        logic        err;
        start_test("reset state");
        check_word("o_bus_clk_en", 32'(o_bus_clk_en), 32'd0);
        apb_read(8'(REG_STATUS), st, err);
        check_word("STATUS", st, 32'h0);
        wait_clocks(16);
        check_word("bus strobes after reset", 32'(mon_q.size()), 32'd0);
        apb_read(8'(REG_RDATA), st, err);   // Empty FIFO.
        check_word("o_pslverr on empty RDATA", 32'(err), 32'd1);
        apb_read(8'(REG_STATUS), st, err);
        check_word("STATUS", st, 32'h2);    // Halt only.
        apb_write(8'(REG_CTRL), 32'h2, err);
        apb_read(8'(REG_STATUS), st, err);
        check_word("STATUS", st, 32'h0);
        end_test();
    endtask

    task automatic test_send_order();
        logic [31:0] st;
        logic        err;
        logic [4:0]  r;
        start_test("send order");
        repeat (10) begin
            r = 5'($urandom());
            exp_q.push_back(entry_from_bits(r));
            apb_write(8'(REG_PROG), 32'(r), err);
            check_word("o_pslverr on PROG", 32'(err), 32'd0);
        end
        wait_sent(10);
        wait_idle();
        check_sent(10);
        apb_read(8'(REG_STATUS), st, err);
        check_word("STATUS", st, 32'h0);
        end_test();
    endtask

    task automatic test_read_sequence();
        logic [31:0] st;
        logic        err;
        nibble_t     expect_n;
        nibble_t     got;
        nibble_t     shift;
        start_test("read sequence");
        expect_n = 4'($urandom());
        apb_write(8'(REG_PROG), {27'h0, BUS_CMD, expect_n}, err);  // Load counter.
        wait_idle();
        apb_write(8'(REG_CTRL), 32'h1, err);
        repeat (6) begin
            pop_rdata(got);
            check_nibble("o_prdata RDATA", got, expect_n);
            expect_n = expect_n + 4'd1;
        end
        wait_fifo(FIFO_DEPTH);               // Reads left pending.
        wait_clocks(32);
        apb_read(8'(REG_STATUS), st, err);
        check_word("STATUS FIFO count", 32'(st[11:8]), 32'(FIFO_DEPTH));
        stop_reads_and_drain(expect_n);
        shift = 4'($urandom());
        apb_write(8'(REG_PROG), {27'h0, BUS_DATA, shift}, err);
        wait_idle();
        expect_n = expect_n + shift;         // Data adds to counter.
        apb_write(8'(REG_CTRL), 32'h1, err);
        repeat (4) begin
            pop_rdata(got);
            check_nibble("o_prdata RDATA", got, expect_n);
            expect_n = expect_n + 4'd1;
        end
        stop_reads_and_drain(expect_n);
        end_test();
    endtask

    task automatic test_ring_full();
        logic [31:0] st;
        logic        err;
        logic [4:0]  r;
        int          i;
        start_test("ring full while halted");
        apb_read(8'(REG_RDATA), st, err);   // Sets halt.
        check_word("o_pslverr on empty RDATA", 32'(err), 32'd1);
        for (i = 0; i < 32; i++) begin
            r = 5'($urandom());
            apb_write(8'(REG_PROG), 32'(r), err);
            check_word("o_pslverr on PROG", 32'(err), (i == 31) ? 32'd1 : 32'd0);
            if (i < 31) begin
                exp_q.push_back(entry_from_bits(r));
            end
        end
        apb_read(8'(REG_STATUS), st, err);
        check_word("STATUS", st, 32'h7F);    // Busy, halt, 31 pending.
        check_word("bus strobes while halted", 32'(mon_q.size()), 32'd0);
        apb_write(8'(REG_CTRL), 32'h2, err);
        wait_sent(31);
        wait_idle();
        check_sent(31);
        end_test();
    endtask

    task automatic test_halt_freeze();
        logic [31:0] st;
        logic        err;
        logic [4:0]  r;
        start_test("halt freezes bus");
        apb_read(8'(REG_RDATA), st, err);
        check_word("o_pslverr on empty RDATA", 32'(err), 32'd1);
        repeat (3) begin
            r = 5'($urandom());
            exp_q.push_back(entry_from_bits(r));
            apb_write(8'(REG_PROG), 32'(r), err);
        end
        wait_clocks(40);
        check_word("bus strobes while halted", 32'(mon_q.size()), 32'd0);
        apb_write(8'(REG_CTRL), 32'h2, err);
        wait_sent(3);
        wait_idle();
        check_sent(3);
        end_test();
    endtask

    task automatic test_unmapped();
        logic [31:0] st;
        logic        err;
        start_test("unmapped address");
        apb_write(8'h10, 32'h0, err);
        check_word("o_pslverr at 0x10", 32'(err), 32'd1);
        apb_read(8'(REG_STATUS), st, err);
        check_word("STATUS", st, 32'h2);
        apb_write(8'(REG_CTRL), 32'h2, err);
        apb_write(8'h06, 32'h0, err);       // Offset between registers.
        check_word("o_pslverr at 0x06", 32'(err), 32'd1);
        apb_write(8'(REG_CTRL), 32'h2, err);
        apb_read(8'(REG_STATUS), st, err);
        check_word("STATUS", st, 32'h0);
        end_test();
    endtask

    initial begin
        void'($urandom(32'hc3bd_7263));
        n_checks  = 0;
        n_errors  = 0;
        n_tests   = 0;
        n_failed  = 0;
        i_reset   = 1'b1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = 8'h0;
        i_pwdata  = 32'h0;
        repeat (4) @(posedge i_clk);
        #DRIVE_DLY;
        i_reset = 1'b0;
        test_reset_state();
        test_send_order();
        test_read_sequence();
        test_ring_full();
        test_halt_freeze();
        test_unmapped();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0 && n_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sources.f
source/saturn_bus_pkg.sv
source/saturn_apb_regs.sv
source/saturn_bus_program.sv
source/saturn_bus_sequencer.sv
source/saturn_read_fifo.sv
source/saturn_bus_top.sv
sim/saturn_bus_model.sv
sim/tb_saturn_bus.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_saturn_bus -f sources.f -o tb_saturn_bus

output=$(./obj_dir/tb_saturn_bus)
echo "$output"

if grep -qx "Regression passed" <<< "$output"; then
    exit 0
fi
exit 1
